//--- Makefile
TOP             ?= tb_rv_core
FILELIST        ?= rv_core.f
OBJ_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

//--- dv/rv_core_checker.sv
`timescale 1ns/1ps

module rv_core_checker
(
	input  logic        clk,
	input  logic        rst,
	input  logic        active,
	input  logic [63:0] name,
	input  logic [31:0] exp_pc,
	input  logic        exp_store,
	input  logic [31:0] exp_addr,
	input  logic [31:0] exp_data,
	input  logic [31:0] pc,
	input  logic [31:0] mem_addr,
	input  logic [31:0] out_bus,
	input  logic        mem_we,
	output int unsigned tests,
	output int unsigned errors
);

	logic [63:0] t_name;
	logic [31:0] t_pc;
	logic        t_store;
	logic [31:0] t_addr;
	logic [31:0] t_data;
	logic        t_valid;
	logic [1:0]  phase; // Zero right after a closing edge
	int unsigned strobes;
	int unsigned bad;
	int unsigned fails;

	// Expected values are taken at each decode edge
	always @(posedge clk)
	begin
		if (rst)
		begin
			phase   <= 2'd0;
			t_valid <= 1'b0;
		end
		else if (phase == 2'd0)
		begin
			t_valid <= active;
			if (active)
			begin
				phase   <= 2'd1;
				t_name  <= name;
				t_pc    <= exp_pc;
				t_store <= exp_store;
				t_addr  <= exp_addr;
				t_data  <= exp_data;
			end
		end
		else
			phase <= phase + 2'd1;
	end

	////////////////////
	// Compare
	////////////////////

	always @(negedge clk)
	begin
		if (rst)
		begin
			tests   = 0;
			errors  = 0;
			strobes = 0;
			bad     = 0;
		end
		else if (t_valid && phase != 2'd0)
		begin
			if (mem_we)
			begin
				strobes = strobes + 1;
				if (t_store && mem_addr !== t_addr)
				begin
					$display("Mismatch %0s mem_addr expected %h actual %h", t_name, t_addr, mem_addr);
					bad = bad + 1;
				end
				if (t_store && out_bus !== t_data)
				begin
					$display("Mismatch %0s out_bus expected %h actual %h", t_name, t_data, out_bus);
					bad = bad + 1;
				end
			end
		end
		else if (t_valid)
		begin
			fails = bad;
			if (pc !== t_pc) // pc moved on the closing edge
			begin
				$display("Mismatch %0s pc expected %h actual %h", t_name, t_pc, pc);
				fails = fails + 1;
			end
			if (t_store && strobes != 1)
			begin
				$display("%0s should write memory once but wrote %0d times", t_name, strobes);
				fails = fails + 1;
			end
			if (!t_store && strobes != 0)
			begin
				$display("%0s wrote memory although it is no store", t_name);
				fails = fails + 1;
			end
			$display("%s %0s", (fails == 0) ? "ok  " : "FAIL", t_name);
			tests = tests + 1;
			if (fails != 0)
				errors = errors + 1;
			strobes = 0;
			bad     = 0;
		end
	end

endmodule

//--- dv/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

	logic               clk;
	logic               rst;
	rv_core_pkg::word_t inst;
	rv_core_pkg::word_t in_bus;
	rv_core_pkg::word_t pc;
	rv_core_pkg::word_t mem_addr;
	rv_core_pkg::word_t out_bus;
	logic               mem_we;

	// Entry under test, held until the next decode edge
	logic        active;
	logic [63:0] cur_name;
	logic [31:0] cur_pc;
	logic        cur_store;
	logic [31:0] cur_addr;
	logic [31:0] cur_data;
	int unsigned tests;
	int unsigned errors;

	////////////////////
	// Program table
	////////////////////

	logic [63:0] names [$];
	logic [31:0] insts [$];
	logic [31:0] buses [$];
	logic [31:0] next_pcs [$];
	logic        stores [$];
	logic [31:0] addrs [$];
	logic [31:0] datas [$];

	logic [31:0] p; // Model pc while the table is built
	logic [31:0] r;
	logic [31:0] lk;
	integer      seed;
	int unsigned cycles;
	int unsigned limit;

	rv_core uut
	(
		.clk      (clk),
		.rst      (rst),
		.inst     (inst),
		.in_bus   (in_bus),
		.pc       (pc),
		.mem_addr (mem_addr),
		.out_bus  (out_bus),
		.mem_we   (mem_we)
	);

	rv_core_checker u_checker
	(
		.clk       (clk),
		.rst       (rst),
		.active    (active),
		.name      (cur_name),
		.exp_pc    (cur_pc),
		.exp_store (cur_store),
		.exp_addr  (cur_addr),
		.exp_data  (cur_data),
		.pc        (pc),
		.mem_addr  (mem_addr),
		.out_bus   (out_bus),
		.mem_we    (mem_we),
		.tests     (tests),
		.errors    (errors)
	);

	////////////////////
	// Instruction encoders
	////////////////////

	function automatic logic [31:0] enc_i(logic [31:0] imm, int rs1, logic [2:0] f3, int rd,
		logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
	endfunction

	function automatic logic [31:0] enc_s(logic [31:0] imm, int rs1, int rs2, logic [2:0] f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(logic [31:0] imm, int rs1, int rs2, logic [2:0] f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_u(logic [31:0] imm, int rd, logic [6:0] op);
		return {imm[19:0], rd[4:0], op};
	endfunction

	function automatic logic [31:0] enc_j(logic [31:0] imm, int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic add_test(logic [63:0] nm, logic [31:0] ins, logic [31:0] bus,
		logic [31:0] npc, logic st, logic [31:0] addr, logic [31:0] data);
		names.push_back(nm);
		insts.push_back(ins);
		buses.push_back(bus);
		next_pcs.push_back(npc);
		stores.push_back(st);
		addrs.push_back(addr);
		datas.push_back(data);
		p = npc;
	endtask

	task automatic add_step(logic [63:0] nm, logic [31:0] ins, logic [31:0] npc);
		add_test(nm, ins, 32'h0, npc, 1'b0, 32'h0, 32'h0);
	endtask

	// SW of one register to 0x40
	task automatic store_reg(logic [63:0] nm, int rs, logic [31:0] data);
		add_test(nm, enc_s(32'h40, 0, rs, 3'b010), 32'h0, p + 4, 1'b1, 32'h40, data);
	endtask

	task automatic build_table();
		p = 32'h0;
		add_step("lui", enc_u(32'h12345, 1, 7'b0110111), p + 4);
		add_step("auipc", enc_u(32'hfedcb, 2, 7'b0010111), p + 4); // x2 = 0xfedcb000 + 4
		add_test("sw_lui", enc_s(32'h10, 0, 1, 3'b010), 32'h0, p + 4, 1'b1, 32'h10,
			32'h1234_5000);
		add_test("sw_auipc", enc_s(-4, 1, 2, 3'b010), 32'h0, p + 4, 1'b1, 32'h1234_4ffc,
			32'hfedc_b004);
		add_test("sh", enc_s(-2, 0, 2, 3'b001), 32'h0, p + 4, 1'b1, 32'hffff_fffe,
			32'h0000_b004);
		add_test("sb", enc_s(5, 1, 2, 3'b000), 32'h0, p + 4, 1'b1, 32'h1234_5005,
			32'h0000_0004);

		// Loads into x5, sign bits of byte and half forced high
		r = $random(seed) | 32'h0000_8080;
		add_test("lb", enc_i(0, 0, 3'b000, 5, 7'b0000011), r, p + 4, 1'b0, 32'h0, 32'h0);
		store_reg("sw_lb", 5, {{24{r[7]}}, r[7:0]});
		r = $random(seed) | 32'h0000_8080;
		add_test("lh", enc_i(0, 0, 3'b001, 5, 7'b0000011), r, p + 4, 1'b0, 32'h0, 32'h0);
		store_reg("sw_lh", 5, {{16{r[15]}}, r[15:0]});
		r = $random(seed) | 32'h0000_8080;
		add_test("lw", enc_i(0, 0, 3'b010, 5, 7'b0000011), r, p + 4, 1'b0, 32'h0, 32'h0);
		store_reg("sw_lw", 5, r);
		r = $random(seed) | 32'h0000_8080;
		add_test("lbu", enc_i(0, 0, 3'b100, 5, 7'b0000011), r, p + 4, 1'b0, 32'h0, 32'h0);
		store_reg("sw_lbu", 5, {24'h0, r[7:0]});
		r = $random(seed) | 32'h0000_8080;
		add_test("lhu", enc_i(0, 0, 3'b101, 5, 7'b0000011), r, p + 4, 1'b0, 32'h0, 32'h0);
		store_reg("sw_lhu", 5, {16'h0, r[15:0]});

		// x1 positive, x2 negative, so signed and unsigned order differ
		add_step("beq_t", enc_b(16, 1, 1, 3'b000), p + 16);
		add_step("beq_n", enc_b(16, 1, 2, 3'b000), p + 4);
		add_step("bne_t", enc_b(-8, 1, 2, 3'b001), p - 8);
		add_step("bne_n", enc_b(-8, 1, 1, 3'b001), p + 4);
		add_step("blt_t", enc_b(32, 2, 1, 3'b100), p + 32);
		add_step("blt_n", enc_b(32, 1, 2, 3'b100), p + 4);
		add_step("bge_t", enc_b(-16, 1, 2, 3'b101), p - 16);
		add_step("bge_n", enc_b(-16, 2, 1, 3'b101), p + 4);
		add_step("bltu_t", enc_b(64, 1, 2, 3'b110), p + 64);
		add_step("bltu_n", enc_b(64, 2, 1, 3'b110), p + 4);
		add_step("bgeu_t", enc_b(100, 2, 1, 3'b111), p + 100);
		add_step("bgeu_n", enc_b(100, 1, 2, 3'b111), p + 4);

		// Jumps, link values shown by the next store
		lk = p + 4;
		add_step("jal", enc_j(32'h100, 6), p + 32'h100);
		store_reg("sw_jal", 6, lk);
		lk = p + 4;
		add_step("jalr", enc_i(32'h33, 1, 3'b000, 7, 7'b1100111), 32'h1234_5032);
		store_reg("sw_jalr", 7, lk);
		add_step("lui_x0", enc_u(32'habcde, 0, 7'b0110111), p + 4);
		store_reg("sw_x0", 0, 32'h0);
	endtask

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Run limit in clock cycles
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (limit != 0 && cycles > limit)
		begin
			$display("Timeout after %0d cycles, only %0d tests finished", cycles, tests);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial
	begin
		seed      = 32'h85e2_d17d;
		cycles    = 0;
		limit     = 0;
		rst       = 1'b1;
		inst      = 32'h0;
		in_bus    = 32'h0;
		active    = 1'b0;
		cur_name  = 64'h0;
		cur_pc    = 32'h0;
		cur_store = 1'b0;
		cur_addr  = 32'h0;
		cur_data  = 32'h0;
		build_table();
		limit = names.size() * 4 + 4 + 20;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst    = 1'b0;
		active = 1'b1;
		foreach (insts[i])
		begin
			inst      = insts[i];
			in_bus    = buses[i];
			cur_name  = names[i];
			cur_pc    = next_pcs[i];
			cur_store = stores[i];
			cur_addr  = addrs[i];
			cur_data  = datas[i];
			repeat (4) @(negedge clk); // One instruction
		end
		active = 1'b0;
		@(posedge clk);
		$display("Tests run %0d of %0d, failed %0d", tests, names.size(), errors);
		if (errors == 0 && tests == names.size())
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- hw/rv_core.sv
`timescale 1ns/1ps

module rv_core
(
	input  logic               clk,
	input  logic               rst,
	input  rv_core_pkg::word_t inst,
	input  rv_core_pkg::word_t in_bus,
	output rv_core_pkg::word_t pc,
	output rv_core_pkg::word_t mem_addr,
	output rv_core_pkg::word_t out_bus,
	output logic               mem_we
);

	rv_core_pkg::state_e   state;
	logic [6:0]            opcode;
	logic [2:0]            funct3;
	rv_core_pkg::word_t    imm;
	rv_core_pkg::reg_idx_t rs1_idx;
	rv_core_pkg::reg_idx_t rs2_idx;
	rv_core_pkg::reg_idx_t wr_idx;
	logic                  rd_req_en;
	logic                  wr_en;
	rv_core_pkg::word_t    rs1_data;
	rv_core_pkg::word_t    rs2_data;
	rv_core_pkg::word_t    rd_data; // Write-back value
	rv_core_pkg::word_t    next_pc;

	rv_sequencer u_sequencer
	(
		.clk       (clk),
		.rst       (rst),
		.inst      (inst),
		.next_pc   (next_pc),
		.pc        (pc),
		.state     (state),
		.opcode    (opcode),
		.funct3    (funct3),
		.imm       (imm),
		.rs1_idx   (rs1_idx),
		.rs2_idx   (rs2_idx),
		.rd_req_en (rd_req_en),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx)
	);

	rv_regfile u_regfile
	(
		.clk       (clk),
		.rst       (rst),
		.rs1_idx   (rs1_idx),
		.rs2_idx   (rs2_idx),
		.rd_req_en (rd_req_en),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx),
		.rd_data   (rd_data),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data)
	);

	rv_execute u_execute
	(
		.clk      (clk),
		.rst      (rst),
		.state    (state),
		.opcode   (opcode),
		.funct3   (funct3),
		.imm      (imm),
		.pc       (pc),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.in_bus   (in_bus),
		.rd_data  (rd_data),
		.next_pc  (next_pc),
		.mem_addr (mem_addr),
		.out_bus  (out_bus),
		.mem_we   (mem_we)
	);

endmodule

//--- hw/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

////////////////////
// Datapath geometry
////////////////////

// Data and address width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_REG_COUNT 32

////////////////////
// Program counter
////////////////////

`define RV_RESET_PC 32'h0000_0000 // First fetch address

// One instruction word in bytes
`define RV_INSTR_BYTES 4

`endif

//--- hw/rv_core_pkg.sv
`include "rv_core_cfg.svh"

package rv_core_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;

	// Register index, x0 to x31
	typedef logic [4:0] reg_idx_t;

	////////////////////
	// Sequencer states
	////////////////////

	// Gray order, one bit flips per step
	typedef enum logic [1:0]
	{
		S_DECODE = 2'b00,
		S_READ   = 2'b01,
		S_EXEC   = 2'b11,
		S_WB     = 2'b10
	} state_e;

endpackage

//--- hw/rv_execute.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_execute
(
	input  logic                clk,
	input  logic                rst,
	input  rv_core_pkg::state_e state,
	input  logic [6:0]          opcode,
	input  rv_isa_pkg::funct3_t funct3,
	input  rv_core_pkg::word_t  imm,
	input  rv_core_pkg::word_t  pc,
	input  rv_core_pkg::word_t  rs1_data,
	input  rv_core_pkg::word_t  rs2_data,
	input  rv_core_pkg::word_t  in_bus,
	output rv_core_pkg::word_t  rd_data,
	output rv_core_pkg::word_t  next_pc,
	output rv_core_pkg::word_t  mem_addr,
	output rv_core_pkg::word_t  out_bus,
	output logic                mem_we
);

	rv_isa_pkg::opcode_e op;
	rv_core_pkg::word_t  pc_plus4;
	rv_core_pkg::word_t  pc_imm;   // Branch, JAL and AUIPC
	rv_core_pkg::word_t  addr_sum; // Memory address and JALR target
	rv_core_pkg::word_t  st_data;
	rv_core_pkg::word_t  ld_data;
	rv_core_pkg::word_t  res_q;
	logic                take;

	assign op       = rv_isa_pkg::opcode_e'(opcode);
	assign pc_plus4 = pc + rv_core_pkg::word_t'(`RV_INSTR_BYTES);
	assign pc_imm   = pc + imm;
	assign addr_sum = rs1_data + imm;

	////////////////////
	// Compare and store data
	////////////////////

	always_comb
	begin
		case (rv_isa_pkg::branch_e'(funct3))
			rv_isa_pkg::BEQ:  take = (rs1_data == rs2_data);
			rv_isa_pkg::BNE:  take = (rs1_data != rs2_data);
			rv_isa_pkg::BLT:  take = ($signed(rs1_data) < $signed(rs2_data));
			rv_isa_pkg::BGE:  take = ($signed(rs1_data) >= $signed(rs2_data));
			rv_isa_pkg::BLTU: take = (rs1_data < rs2_data);
			rv_isa_pkg::BGEU: take = (rs1_data >= rs2_data);
			default:          take = 1'b0;
		endcase
	end

	always_comb
	begin
		case (rv_isa_pkg::store_e'(funct3))
			rv_isa_pkg::SB: st_data = {24'b0, rs2_data[7:0]};
			rv_isa_pkg::SH: st_data = {16'b0, rs2_data[15:0]};
			rv_isa_pkg::SW: st_data = rs2_data;
			default:        st_data = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			next_pc <= `RV_RESET_PC;
		else if (state == rv_core_pkg::S_EXEC)
		begin
			case (op)
				rv_isa_pkg::JAL:    next_pc <= pc_imm;
				rv_isa_pkg::JALR:   next_pc <= {addr_sum[31:1], 1'b0};
				rv_isa_pkg::BRANCH: next_pc <= take ? pc_imm : pc_plus4;
				default:            next_pc <= pc_plus4; // Unknown opcodes fall through
			endcase
		end
	end

	// Result and memory side of the instruction
	always_ff @(posedge clk)
	begin
		if (state == rv_core_pkg::S_EXEC)
		begin
			mem_addr <= addr_sum;
			out_bus  <= st_data;
			case (op)
				rv_isa_pkg::LUI:   res_q <= imm;
				rv_isa_pkg::AUIPC: res_q <= pc_imm;
				default:           res_q <= pc_plus4; // Link value
			endcase
		end
	end

	////////////////////
	// Write-back
	////////////////////

	always_comb
	begin
		case (rv_isa_pkg::load_e'(funct3))
			rv_isa_pkg::LB:  ld_data = {{24{in_bus[7]}}, in_bus[7:0]};
			rv_isa_pkg::LH:  ld_data = {{16{in_bus[15]}}, in_bus[15:0]};
			rv_isa_pkg::LBU: ld_data = {24'b0, in_bus[7:0]};
			rv_isa_pkg::LHU: ld_data = {16'b0, in_bus[15:0]};
			default:         ld_data = in_bus;
		endcase
	end

	assign rd_data = (op == rv_isa_pkg::LOAD) ? ld_data : res_q;
	assign mem_we  = (state == rv_core_pkg::S_WB) && (op == rv_isa_pkg::STORE);

	// Strobe comes right after the address was registered
	a_we_in_wb: assert property (@(posedge clk) disable iff (rst)
		mem_we |-> $past(state) == rv_core_pkg::S_EXEC);

endmodule

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

	typedef logic [2:0] funct3_t;

	////////////////////
	// Major opcodes
	////////////////////

	typedef enum logic [6:0]
	{
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011
	} opcode_e;

	// Branch compare selects
	typedef enum funct3_t
	{
		BEQ  = 3'b000,
		BNE  = 3'b001,
		BLT  = 3'b100,
		BGE  = 3'b101,
		BLTU = 3'b110,
		BGEU = 3'b111
	} branch_e;

	typedef enum funct3_t
	{
		LB  = 3'b000,
		LH  = 3'b001,
		LW  = 3'b010,
		LBU = 3'b100, // Zero-extended
		LHU = 3'b101
	} load_e;

	typedef enum funct3_t
	{
		SB = 3'b000,
		SH = 3'b001,
		SW = 3'b010
	} store_e;

	////////////////////
	// Field positions
	////////////////////

	localparam int unsigned OPC_LSB = 0;
	localparam int unsigned RD_LSB  = 7;
	localparam int unsigned F3_LSB  = 12;
	localparam int unsigned RS1_LSB = 15;
	localparam int unsigned RS2_LSB = 20;

	localparam int unsigned REG_ZERO = 0; // Hard-wired zero register

endpackage

//--- hw/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_regfile
(
	input  logic                  clk,
	input  logic                  rst,
	input  rv_core_pkg::reg_idx_t rs1_idx,
	input  rv_core_pkg::reg_idx_t rs2_idx,
	input  logic                  rd_req_en,
	input  logic                  wr_en,
	input  rv_core_pkg::reg_idx_t wr_idx,
	input  rv_core_pkg::word_t    rd_data,
	output rv_core_pkg::word_t    rs1_data,
	output rv_core_pkg::word_t    rs2_data
);

	rv_core_pkg::word_t regs [`RV_REG_COUNT];

	// x0 never leaves the file as anything but zero
	function automatic rv_core_pkg::word_t read_port(input rv_core_pkg::reg_idx_t idx);
		if (idx == rv_core_pkg::reg_idx_t'(rv_isa_pkg::REG_ZERO))
			return '0;
		return regs[idx];
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `RV_REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
			regs[wr_idx] <= rd_data;
	end

	// Operand registers, loaded in the read state
	always_ff @(posedge clk)
	begin
		if (rd_req_en)
		begin
			rs1_data <= read_port(rs1_idx);
			rs2_data <= read_port(rs2_idx);
		end
	end

	a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> wr_idx != rv_core_pkg::reg_idx_t'(rv_isa_pkg::REG_ZERO));

endmodule

//--- hw/rv_sequencer.sv
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_sequencer
(
	input  logic                  clk,
	input  logic                  rst,
	input  rv_core_pkg::word_t    inst,
	input  rv_core_pkg::word_t    next_pc,
	output rv_core_pkg::word_t    pc,
	output rv_core_pkg::state_e   state,
	output rv_isa_pkg::opcode_e   opcode,
	output rv_isa_pkg::funct3_t   funct3,
	output rv_core_pkg::word_t    imm,
	output rv_core_pkg::reg_idx_t rs1_idx,
	output rv_core_pkg::reg_idx_t rs2_idx,
	output logic                  rd_req_en,
	output logic                  wr_en,
	output rv_core_pkg::reg_idx_t wr_idx
);

	rv_core_pkg::word_t ir; // Held for the whole instruction
	logic               writes_rd;

	////////////////////
	// State and pc
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= rv_core_pkg::S_DECODE;
			pc    <= `RV_RESET_PC;
		end
		else
		begin
			case (state)
				rv_core_pkg::S_DECODE: state <= rv_core_pkg::S_READ;
				rv_core_pkg::S_READ:   state <= rv_core_pkg::S_EXEC;
				rv_core_pkg::S_EXEC:   state <= rv_core_pkg::S_WB;
				default:
				begin
					state <= rv_core_pkg::S_DECODE;
					pc    <= next_pc; // Closing edge of write-back
				end
			endcase
		end
	end

	// The input word is only valid around the decode edge
	always_ff @(posedge clk)
	begin
		if (state == rv_core_pkg::S_DECODE)
			ir <= inst;
	end

	////////////////////
	// Field decode
	////////////////////

	assign opcode  = rv_isa_pkg::opcode_e'(ir[rv_isa_pkg::OPC_LSB +: 7]);
	assign funct3  = ir[rv_isa_pkg::F3_LSB +: 3];
	assign rs1_idx = ir[rv_isa_pkg::RS1_LSB +: 5];
	assign rs2_idx = ir[rv_isa_pkg::RS2_LSB +: 5];
	assign wr_idx  = ir[rv_isa_pkg::RD_LSB +: 5];

	// Immediate, sign-extended to full width
	always_comb
	begin
		case (opcode)
			rv_isa_pkg::LUI,
			rv_isa_pkg::AUIPC:  imm = {ir[31:12], 12'b0};
			rv_isa_pkg::JAL:    imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
			rv_isa_pkg::BRANCH: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
			rv_isa_pkg::STORE:  imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
			default:            imm = {{20{ir[31]}}, ir[31:20]}; // I-type, JALR and loads
		endcase
	end

	// Unknown opcodes leave the register file alone
	assign writes_rd = opcode inside {rv_isa_pkg::LUI, rv_isa_pkg::AUIPC, rv_isa_pkg::JAL,
		rv_isa_pkg::JALR, rv_isa_pkg::LOAD};

	assign rd_req_en = (state == rv_core_pkg::S_READ);
	assign wr_en     = (state == rv_core_pkg::S_WB) && writes_rd &&
		(wr_idx != rv_core_pkg::reg_idx_t'(rv_isa_pkg::REG_ZERO));

	////////////////////
	// Checks
	////////////////////

	a_state_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(state));

endmodule

//--- rv_core.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/rv_core_pkg.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_sequencer.sv
hw/rv_core.sv
dv/rv_core_checker.sv
dv/tb_rv_core.sv
